// ==== rtl/exe_pkg.sv ====
// Shared types and constants of the RV32I execute stage
// Widths and encodings are fixed to RV32 and match the decode stage
package exe_pkg;

	localparam int XLEN = 32;

	typedef enum logic [3:0] {
		ALU_ADD  = 4'd0,
		ALU_SUB  = 4'd1,
		ALU_SLL  = 4'd2,
		ALU_SLT  = 4'd3,
		ALU_SLTU = 4'd4, // Also picked by decode for BLTU and BGEU
		ALU_XOR  = 4'd5,
		ALU_SRL  = 4'd6,
		ALU_SRA  = 4'd7,
		ALU_OR   = 4'd8,
		ALU_AND  = 4'd9
	} alu_op_e;

	typedef enum logic [1:0] {
		SRC1_ZERO = 2'd0, // LUI path
		SRC1_REG1 = 2'd1,
		SRC1_PC   = 2'd2  // AUIPC, JAL and JALR link
	} src1_sel_e;

	typedef enum logic [1:0] {
		SRC2_ZERO = 2'd0,
		SRC2_REG2 = 2'd1,
		SRC2_IMM  = 2'd2,
		SRC2_FOUR = 2'd3  // Link address is pc + 4
	} src2_sel_e;

	typedef enum logic [1:0] {
		ST_NONE = 2'd0,
		ST_SB   = 2'd1,
		ST_SH   = 2'd2,
		ST_SW   = 2'd3
	} store_type_e;

	typedef enum logic [2:0] {
		LD_NONE = 3'd0,
		LD_LB   = 3'd1,
		LD_LH   = 3'd2,
		LD_LW   = 3'd3,
		LD_LBU  = 3'd4,
		LD_LHU  = 3'd5
	} load_type_e;

	typedef enum logic [2:0] {
		BR_NONE = 3'd0,
		BR_BEQ  = 3'd1,
		BR_BNE  = 3'd2,
		BR_BLT  = 3'd3,
		BR_BGE  = 3'd4,
		BR_BLTU = 3'd5,
		BR_BGEU = 3'd6  // Code 7 is illegal
	} branch_type_e;

	localparam logic [XLEN-1:0] STORE_SB_MASK = 32'h0000_00ff;
	localparam logic [XLEN-1:0] STORE_SH_MASK = 32'h0000_ffff;
	localparam logic [XLEN-1:0] STORE_SW_MASK = 32'hffff_ffff;

	typedef struct packed {
		logic [XLEN-1:0] reg1;
		logic [XLEN-1:0] reg2;       // Also the store data
		logic [XLEN-1:0] pc;
		logic [XLEN-1:0] imm;
		alu_op_e         alu_op;
		src1_sel_e       src1_sel;
		src2_sel_e       src2_sel;
		logic            wd;         // Register writeback enable
		logic [4:0]      wreg;       // Destination register index
		store_type_e     store_type;
		load_type_e      load_type;
		branch_type_e    branch_type;
	} exe_req_t;

	typedef struct packed {
		logic [XLEN-1:0] alu_result; // Also the memory address
		logic [XLEN-1:0] mem_wdata;
		logic            mem_wen;
		logic            wd;
		logic [4:0]      wreg;
		load_type_e      load_type;
		logic            branch_request;
	} exe_resp_t;

endpackage

// ==== rtl/exe_alu.sv ====
// Purely combinational integer ALU for the RV32I base set
// Shift amounts use only src2[4:0]; the less flag is unsigned for ALU_SLTU only
`timescale 1ns/1ps

module exe_alu (
	input  logic [exe_pkg::XLEN-1:0] src1_i,
	input  logic [exe_pkg::XLEN-1:0] src2_i,
	input  exe_pkg::alu_op_e         alu_op_i,
	output logic [exe_pkg::XLEN-1:0] result_o,
	output logic                     less_o,
	output logic                     equal_o
);

	import exe_pkg::*;

	logic [XLEN:0]   diff;     // One extra bit holds the borrow
	logic            less_s;
	logic            less_u;
	logic [4:0]      shamt;

	assign diff   = {1'b0, src1_i} - {1'b0, src2_i};
	assign less_u = diff[XLEN]; // Borrow out means src1 < src2 unsigned

	// Differing signs decide directly, otherwise the difference sign does
	assign less_s = (src1_i[XLEN-1] != src2_i[XLEN-1]) ? src1_i[XLEN-1]
	                                                   : diff[XLEN-1];

	assign shamt   = src2_i[4:0];
	assign less_o  = (alu_op_i == ALU_SLTU) ? less_u : less_s;
	assign equal_o = (src1_i == src2_i);

	always_comb begin
		case (alu_op_i)
			ALU_ADD: begin
				result_o = src1_i + src2_i;
			end
			ALU_SUB: begin
				result_o = diff[XLEN-1:0]; // Shares the compare subtractor
			end
			ALU_SLL: begin
				result_o = src1_i << shamt;
			end
			ALU_SLT: begin
				result_o = {{(XLEN-1){1'b0}}, less_s};
			end
			ALU_SLTU: begin
				result_o = {{(XLEN-1){1'b0}}, less_u};
			end
			ALU_XOR: begin
				result_o = src1_i ^ src2_i;
			end
			ALU_SRL: begin
				result_o = src1_i >> shamt;
			end
			ALU_SRA: begin
				result_o = $unsigned($signed(src1_i) >>> shamt); // Sign fill
			end
			ALU_OR: begin
				result_o = src1_i | src2_i;
			end
			ALU_AND: begin
				result_o = src1_i & src2_i;
			end
			default: begin
				result_o = '0;
			end
		endcase
	end

	// Decode only ever issues the ten RV32I operations
	always_comb begin
		if (!$isunknown(alu_op_i)) begin
			assert (alu_op_i inside {ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
			                         ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND})
			else $error("exe_alu: illegal alu_op_i %0d", alu_op_i);
		end
	end

endmodule

// ==== rtl/exe_mem_branch.sv ====
// Purely combinational branch decision and store data masking
// Unsigned branches rely on decode selecting ALU_SLTU so less_i is unsigned
`timescale 1ns/1ps

module exe_mem_branch (
	input  exe_pkg::branch_type_e    branch_type_i,
	input  logic                     less_i,
	input  logic                     equal_i,
	input  exe_pkg::store_type_e     store_type_i,
	input  logic [exe_pkg::XLEN-1:0] store_data_i,
	output logic                     branch_request_o,
	output logic                     mem_wen_o,
	output logic [exe_pkg::XLEN-1:0] mem_wdata_o
);

	import exe_pkg::*;

	logic [XLEN-1:0] store_mask;

	always_comb begin
		case (branch_type_i)
			BR_BEQ:  branch_request_o = equal_i;
			BR_BNE:  branch_request_o = ~equal_i;
			BR_BLT:  branch_request_o = less_i;
			BR_BGE:  branch_request_o = ~less_i;
			BR_BLTU: branch_request_o = less_i;  // less_i is unsigned here
			BR_BGEU: branch_request_o = ~less_i;
			default: branch_request_o = 1'b0;    // BR_NONE and code 7
		endcase
	end

	always_comb begin
		case (store_type_i)
			ST_SB:   store_mask = STORE_SB_MASK;
			ST_SH:   store_mask = STORE_SH_MASK;
			ST_SW:   store_mask = STORE_SW_MASK;
			default: store_mask = '0;            // No store and no data
		endcase
	end

	assign mem_wen_o   = (store_type_i != ST_NONE);
	assign mem_wdata_o = store_data_i & store_mask; // Low lanes only without a shift

	// Decode never produces branch code 7
	always_comb begin
		if (!$isunknown(branch_type_i)) begin
			assert (branch_type_i != 3'd7)
			else $error("exe_mem_branch: illegal branch_type_i 7");
		end
	end

	// Write data stays inside the byte lanes of its store width
	always_comb begin
		if (!$isunknown({store_type_i, store_data_i})) begin
			assert ((store_type_i == ST_SW) ||
			        (store_type_i == ST_SH && mem_wdata_o[XLEN-1:16] == '0) ||
			        (store_type_i == ST_SB && mem_wdata_o[XLEN-1:8] == '0) ||
			        (store_type_i == ST_NONE && mem_wdata_o == '0))
			else $error("exe_mem_branch: mem_wdata_o %h outside store lanes", mem_wdata_o);
		end
	end

endmodule

// ==== rtl/exe_stage.sv ====
// Combinational execute stage with operand select, ALU, branch and store unit
// No forwarding or hazard logic since operands arrive already resolved
`timescale 1ns/1ps

module exe_stage (
	input  exe_pkg::exe_req_t  req_i,
	output exe_pkg::exe_resp_t resp_o
);

	import exe_pkg::*;

	logic [XLEN-1:0] src1;
	logic [XLEN-1:0] src2;
	logic [XLEN-1:0] alu_result;
	logic            alu_less;
	logic            alu_equal;
	logic            branch_request;
	logic            mem_wen;
	logic [XLEN-1:0] mem_wdata;

	// First operand
	always_comb begin
		case (req_i.src1_sel)
			SRC1_REG1: src1 = req_i.reg1;
			SRC1_PC:   src1 = req_i.pc;
			default:   src1 = '0; // SRC1_ZERO
		endcase
	end

	// Second operand
	always_comb begin
		case (req_i.src2_sel)
			SRC2_REG2: src2 = req_i.reg2;
			SRC2_IMM:  src2 = req_i.imm;
			SRC2_FOUR: src2 = 32'd4;  // Link offset
			default:   src2 = '0;
		endcase
	end

	exe_alu u_alu (
		.src1_i   (src1),
		.src2_i   (src2),
		.alu_op_i (req_i.alu_op),
		.result_o (alu_result),
		.less_o   (alu_less),
		.equal_o  (alu_equal)
	);

	exe_mem_branch u_mem_branch (
		.branch_type_i    (req_i.branch_type),
		.less_i           (alu_less),
		.equal_i          (alu_equal),
		.store_type_i     (req_i.store_type),
		.store_data_i     (req_i.reg2),  // Stores always take rs2 directly
		.branch_request_o (branch_request),
		.mem_wen_o        (mem_wen),
		.mem_wdata_o      (mem_wdata)
	);

	always_comb begin
		resp_o.alu_result     = alu_result;
		resp_o.mem_wdata      = mem_wdata;
		resp_o.mem_wen        = mem_wen;
		resp_o.wd             = req_i.wd;        // Writeback controls pass through
		resp_o.wreg           = req_i.wreg;
		resp_o.load_type      = req_i.load_type;
		resp_o.branch_request = branch_request;
	end

	// Code 3 of src1_sel is never issued by decode
	always_comb begin
		if (!$isunknown(req_i.src1_sel)) begin
			assert (req_i.src1_sel != 2'd3)
			else $error("exe_stage: unused src1_sel code 3");
		end
	end

endmodule

// ==== rtl/exe_top.sv ====
// Execute stage plus the execute-to-memory register for one cycle of latency
// The memory stage must take a result every cycle as there is no back-pressure
`timescale 1ns/1ps

module exe_top (
	input  logic               clk_i,
	input  logic               rst_n_i,
	input  logic               valid_i,
	input  exe_pkg::exe_req_t  req_i,
	output logic               valid_o,
	output exe_pkg::exe_resp_t resp_o
);

	import exe_pkg::*;

	exe_resp_t       stage_resp;
	logic            valid_q;
	logic            mem_wen_q;
	logic            branch_request_q;
	logic            wd_q;
	logic [XLEN-1:0] alu_result_q;
	logic [XLEN-1:0] mem_wdata_q;
	logic [4:0]      wreg_q;
	load_type_e      load_type_q;

	exe_stage u_stage (
		.req_i  (req_i),
		.resp_o (stage_resp)
	);

	// Side-effect controls are cleared by reset and by bubbles
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			valid_q          <= 1'b0;
			mem_wen_q        <= 1'b0;
			branch_request_q <= 1'b0;
			wd_q             <= 1'b0;
		end else begin
			valid_q          <= valid_i;
			mem_wen_q        <= valid_i & stage_resp.mem_wen;
			branch_request_q <= valid_i & stage_resp.branch_request;
			wd_q             <= valid_i & stage_resp.wd;
		end
	end

	// Payload is qualified downstream by valid_o
	always_ff @(posedge clk_i) begin
		alu_result_q <= stage_resp.alu_result;
		mem_wdata_q  <= stage_resp.mem_wdata;
		wreg_q       <= stage_resp.wreg;
		load_type_q  <= stage_resp.load_type;
	end

	assign valid_o               = valid_q;
	assign resp_o.alu_result     = alu_result_q;
	assign resp_o.mem_wdata      = mem_wdata_q;
	assign resp_o.mem_wen        = mem_wen_q;
	assign resp_o.wd             = wd_q;
	assign resp_o.wreg           = wreg_q;
	assign resp_o.load_type      = load_type_q;
	assign resp_o.branch_request = branch_request_q;

	// A bubble never reaches memory or the branch unit
	a_bubble_quiet: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		!valid_o |-> (!resp_o.mem_wen && !resp_o.branch_request))
	else $error("exe_top: side effect raised while valid_o is low");

endmodule

// ==== verification/exe_clk_gen.sv ====
// Testbench clock with a 10 ns period
// Reset is held low over the first 3 rising edges, then released
`timescale 1ns/1ps

module exe_clk_gen (
	output logic clk_o,
	output logic rst_n_o
);

	initial begin
		clk_o   = 1'b0;
		rst_n_o = 1'b0;
		repeat (3) @(posedge clk_o);
		rst_n_o <= 1'b1; // Released on the third rising edge
	end

	always #5 clk_o = ~clk_o;

endmodule

// ==== verification/exe_tb_vectors.svh ====
// Vector table included inside the testbench module after the package import
// Operand fields that an entry does not select are randomized before the run
`ifndef EXE_TB_VECTORS_SVH
`define EXE_TB_VECTORS_SVH

localparam logic [31:0] ONES = 32'hffff_ffff;

typedef struct {
	string     name;
	logic      valid;
	exe_req_t  req;
	exe_resp_t exp;
} vec_t;

vec_t vecs[$];

// Plain register op with writeback and no side effects
function automatic exe_req_t base_req(alu_op_e op, src1_sel_e s1, src2_sel_e s2);
	exe_req_t r;
	r          = '0;
	r.alu_op   = op;
	r.src1_sel = s1;
	r.src2_sel = s2;
	r.wd       = 1'b1;
	r.wreg     = 5'(vecs.size() % 31 + 1); // Distinct index per entry
	return r;
endfunction

function automatic exe_req_t alu_req(alu_op_e op, logic [31:0] a, logic [31:0] b);
	exe_req_t r;
	r      = base_req(op, SRC1_REG1, SRC2_REG2);
	r.reg1 = a;
	r.reg2 = b;
	return r;
endfunction

function automatic exe_req_t br_req(branch_type_e br, alu_op_e op, logic [31:0] a,
		logic [31:0] b);
	exe_req_t r;
	r             = alu_req(op, a, b);
	r.branch_type = br;
	r.wd          = 1'b0; // Branches write no register
	return r;
endfunction

// a feeds reg1 and pc, b feeds reg2 and imm
function automatic exe_req_t sel_req(src1_sel_e s1, src2_sel_e s2, logic [31:0] a,
		logic [31:0] b);
	exe_req_t r;
	r      = base_req(ALU_ADD, s1, s2);
	r.reg1 = a;
	r.pc   = a;
	r.reg2 = b;
	r.imm  = b;
	return r;
endfunction

function automatic exe_req_t mem_req(store_type_e st, load_type_e ld, logic [31:0] base,
		logic [31:0] off, logic [31:0] data);
	exe_req_t r;
	r            = base_req(ALU_ADD, SRC1_REG1, SRC2_IMM);
	r.reg1       = base;
	r.imm        = off;
	r.reg2       = data;
	r.store_type = st;
	r.load_type  = ld;
	r.wd         = (ld != LD_NONE); // Only loads write back
	return r;
endfunction

// A bubble clears every side effect of its entry
function automatic void add_vec(string name, exe_req_t r, logic [31:0] res, logic br,
		logic [31:0] wdata = 32'h0, logic valid = 1'b1);
	vec_t v;
	v.name               = name;
	v.valid              = valid;
	v.req                = r;
	v.exp.alu_result     = res;
	v.exp.mem_wdata      = wdata;
	v.exp.mem_wen        = valid && (r.store_type != ST_NONE);
	v.exp.wd             = valid && r.wd;
	v.exp.wreg           = r.wreg;
	v.exp.load_type      = r.load_type;
	v.exp.branch_request = valid && br;
	vecs.push_back(v);
endfunction

task automatic load_vectors();
	add_vec("add", alu_req(ALU_ADD, 32'h5, 32'h3), 32'h8, 1'b0);
	add_vec("add_wrap", alu_req(ALU_ADD, ONES, 32'h1), 32'h0, 1'b0);
	add_vec("sub", alu_req(ALU_SUB, 32'h3, 32'h5), 32'hffff_fffe, 1'b0);
	add_vec("sll", alu_req(ALU_SLL, 32'h1, 32'h1f), 32'h8000_0000, 1'b0);
	add_vec("sll_mask", alu_req(ALU_SLL, 32'h3, 32'h23), 32'h18, 1'b0); // 35 wraps to 3
	add_vec("slt", alu_req(ALU_SLT, ONES, 32'h1), 32'h1, 1'b0);
	add_vec("sltu", alu_req(ALU_SLTU, ONES, 32'h1), 32'h0, 1'b0);
	add_vec("slt_equal", alu_req(ALU_SLT, 32'h7, 32'h7), 32'h0, 1'b0);
	add_vec("xor", alu_req(ALU_XOR, 32'hf0f0, 32'hff00), 32'h0ff0, 1'b0);
	add_vec("srl", alu_req(ALU_SRL, 32'h8000_0000, 32'h4), 32'h0800_0000, 1'b0);
	add_vec("srl_mask", alu_req(ALU_SRL, 32'h8000_0000, 32'h3f), 32'h1, 1'b0);
	add_vec("sra_neg", alu_req(ALU_SRA, 32'h8000_0000, 32'h4), 32'hf800_0000, 1'b0);
	add_vec("sra_mask", alu_req(ALU_SRA, 32'hf000_0000, 32'h24), 32'hff00_0000, 1'b0);
	add_vec("or", alu_req(ALU_OR, 32'h1234_0000, 32'h5678), 32'h1234_5678, 1'b0);
	add_vec("and", alu_req(ALU_AND, 32'hdead_beef, 32'hffff), 32'hbeef, 1'b0);
	add_vec("lui", sel_req(SRC1_ZERO, SRC2_IMM, 32'h0, 32'h12345000), 32'h12345000, 1'b0);
	add_vec("jal_link", sel_req(SRC1_PC, SRC2_FOUR, 32'h1000, 32'h0), 32'h1004, 1'b0);
	add_vec("auipc", sel_req(SRC1_PC, SRC2_IMM, 32'h2000, 32'hfffff000), 32'h1000, 1'b0);
	add_vec("addi", sel_req(SRC1_REG1, SRC2_IMM, 32'h10, ONES), 32'hf, 1'b0);
	add_vec("zero", sel_req(SRC1_ZERO, SRC2_ZERO, 32'h0, 32'h0), 32'h0, 1'b0);
	add_vec("beq_t", br_req(BR_BEQ, ALU_SUB, 32'h5, 32'h5), 32'h0, 1'b1);
	add_vec("beq_nt", br_req(BR_BEQ, ALU_SUB, 32'h5, 32'h6), ONES, 1'b0);
	add_vec("bne_t", br_req(BR_BNE, ALU_SUB, 32'h5, 32'h6), ONES, 1'b1);
	add_vec("bne_nt", br_req(BR_BNE, ALU_SUB, 32'h5, 32'h5), 32'h0, 1'b0);
	add_vec("blt_t", br_req(BR_BLT, ALU_SLT, ONES, 32'h1), 32'h1, 1'b1);
	add_vec("blt_nt", br_req(BR_BLT, ALU_SLT, 32'h1, ONES), 32'h0, 1'b0);
	add_vec("bge_t", br_req(BR_BGE, ALU_SLT, 32'h1, ONES), 32'h0, 1'b1);
	add_vec("bge_eq", br_req(BR_BGE, ALU_SLT, 32'h7, 32'h7), 32'h0, 1'b1);
	add_vec("bge_nt", br_req(BR_BGE, ALU_SLT, ONES, 32'h1), 32'h1, 1'b0);
	add_vec("bltu_t", br_req(BR_BLTU, ALU_SLTU, 32'h1, ONES), 32'h1, 1'b1);
	add_vec("bltu_nt", br_req(BR_BLTU, ALU_SLTU, ONES, 32'h1), 32'h0, 1'b0);
	add_vec("bgeu_t", br_req(BR_BGEU, ALU_SLTU, ONES, 32'h1), 32'h0, 1'b1);
	add_vec("bgeu_nt", br_req(BR_BGEU, ALU_SLTU, 32'h1, ONES), 32'h1, 1'b0);
	add_vec("br_none", br_req(BR_NONE, ALU_SUB, 32'h5, 32'h5), 32'h0, 1'b0);
	add_vec("sb", mem_req(ST_SB, LD_NONE, 32'h1000, 32'h4, 32'hdeadbeef), 32'h1004, 1'b0,
		32'hef);
	add_vec("sh", mem_req(ST_SH, LD_NONE, 32'h1000, 32'h8, 32'hdeadbeef), 32'h1008, 1'b0,
		32'hbeef);
	add_vec("bubble_store", mem_req(ST_SW, LD_LW, 32'h1000, 32'h0, 32'h55), 32'h1000, 1'b0,
		32'h55, 1'b0);
	add_vec("bubble_branch", br_req(BR_BEQ, ALU_SUB, 32'h5, 32'h5), 32'h0, 1'b1, 32'h0, 1'b0);
	add_vec("sw", mem_req(ST_SW, LD_NONE, 32'h1000, 32'hffff_fffc, 32'hdeadbeef), 32'h0ffc,
		1'b0, 32'hdeadbeef);
	add_vec("st_none", mem_req(ST_NONE, LD_NONE, 32'h1000, 32'h0, 32'hdeadbeef), 32'h1000, 1'b0);
	add_vec("lw", mem_req(ST_NONE, LD_LW, 32'h2000, 32'h10, 32'h0), 32'h2010, 1'b0);
	add_vec("lh", mem_req(ST_NONE, LD_LH, 32'h2000, 32'h2, 32'h0), 32'h2002, 1'b0);
	add_vec("lbu", mem_req(ST_NONE, LD_LBU, 32'h2000, ONES, 32'h0), 32'h1fff, 1'b0);
endtask

`endif

// ==== verification/exe_tb.sv ====
// Testbench for exe_top that streams the vector table back to back
// Results are sampled on the falling edge one cycle after they were driven
`timescale 1ns/1ps

module exe_tb;

	import exe_pkg::*;

	logic      clk;
	logic      rst_n;
	logic      valid_i;
	exe_req_t  req_i;
	logic      valid_o;
	exe_resp_t resp_o;
	int        mismatches = 0;
	int        other_errors = 0;
	int        cycles = 0;

	`include "exe_tb_vectors.svh"

	exe_clk_gen u_clk_gen (
		.clk_o   (clk),
		.rst_n_o (rst_n)
	);

	exe_top u_exe_top (
		.clk_i   (clk),
		.rst_n_i (rst_n),
		.valid_i (valid_i),
		.req_i   (req_i),
		.valid_o (valid_o),
		.resp_o  (resp_o)
	);

	task automatic report_mismatch(string name, string field, logic [31:0] exp,
			logic [31:0] act);
		$display("CHECK FAILED %s %s expected %h actual %h", name, field, exp, act);
		mismatches++;
	endtask

	// Payload fields only count when full is set
	task automatic check_resp(string name, exe_resp_t exp, exe_resp_t act, bit full);
		if (full && act.alu_result !== exp.alu_result)
			report_mismatch(name, "alu_result", exp.alu_result, act.alu_result);
		if (full && act.mem_wdata !== exp.mem_wdata)
			report_mismatch(name, "mem_wdata", exp.mem_wdata, act.mem_wdata);
		if (full && act.wreg !== exp.wreg)
			report_mismatch(name, "wreg", 32'(exp.wreg), 32'(act.wreg));
		if (full && act.load_type !== exp.load_type)
			report_mismatch(name, "load_type", 32'(exp.load_type), 32'(act.load_type));
		if (act.mem_wen !== exp.mem_wen)
			report_mismatch(name, "mem_wen", 32'(exp.mem_wen), 32'(act.mem_wen));
		if (act.wd !== exp.wd)
			report_mismatch(name, "wd", 32'(exp.wd), 32'(act.wd));
		if (act.branch_request !== exp.branch_request)
			report_mismatch(name, "branch_request", 32'(exp.branch_request),
				32'(act.branch_request));
	endtask

	task automatic check_valid(string name, logic exp, logic act);
		if (act !== exp)
			report_mismatch(name, "valid_o", 32'(exp), 32'(act));
	endtask

	// Fields the select codes ignore carry random values
	function automatic exe_req_t scramble_unused(exe_req_t r);
		if (r.src1_sel != SRC1_REG1)
			r.reg1 = $urandom;
		if (r.src1_sel != SRC1_PC)
			r.pc = $urandom;
		if (r.src2_sel != SRC2_IMM)
			r.imm = $urandom;
		if (r.src2_sel != SRC2_REG2 && r.store_type == ST_NONE)
			r.reg2 = $urandom;
		return r;
	endfunction

	// Run limit of table length plus slack
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles > vecs.size() + 20) begin
			$display("Timeout after %0d cycles, the vector table did not complete", cycles);
			$display("Simulation failed");
			$finish;
		end
	end

	initial begin
		valid_i = 1'b0;
		req_i   = '0;
		void'($urandom(32'h4d3ee392));
		load_vectors();
		foreach (vecs[i])
			vecs[i].req = scramble_unused(vecs[i].req);
		repeat (3) begin
			@(posedge clk);
			@(negedge clk);
			check_valid("reset", 1'b0, valid_o);
			check_resp("reset", '0, resp_o, 1'b0);
		end
		if (rst_n !== 1'b1) begin
			$display("Reset was not released after 3 cycles");
			other_errors++;
		end
		for (int i = 0; i <= vecs.size(); i++) begin
			@(posedge clk);
			if (i < vecs.size()) begin
				valid_i <= vecs[i].valid;
				req_i   <= vecs[i].req;
			end else begin
				valid_i <= 1'b0; // Drain the last entry
			end
			@(negedge clk);
			if (i == 0) begin
				check_valid("after_reset", 1'b0, valid_o);
				check_resp("after_reset", '0, resp_o, 1'b0);
			end else begin
				check_valid(vecs[i-1].name, vecs[i-1].valid, valid_o);
				check_resp(vecs[i-1].name, vecs[i-1].exp, resp_o, vecs[i-1].valid);
			end
		end
		$display("Errors: %0d value mismatches, %0d other failures", mismatches, other_errors);
		if (mismatches == 0 && other_errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// ==== src.f ====
+incdir+verification
rtl/exe_pkg.sv
rtl/exe_alu.sv
rtl/exe_mem_branch.sv
rtl/exe_stage.sv
rtl/exe_top.sv
verification/exe_clk_gen.sv
verification/exe_tb.sv

// ==== Makefile ====
# Verilator flow for the RV32I execute stage

TOOL      = verilator
TOP       = exe_tb
FILELIST  = src.f
LINT_TOP  = exe_top
FLAGS     = --binary --timing -j 0
LINTFLAGS = --lint-only --timing -Wall
OBJDIR    = obj_dir
LOG       = sim.log
PASS_MSG  = Simulation passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(TOOL) $(LINTFLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

sim: build
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || { echo "Pass message not found in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJDIR) $(LOG)
